/* hdl/ooo_pkg.sv */
package ooo_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_REGS  = 32;
  localparam int REG_W     = 5;   // index width for NUM_REGS
  localparam int ROB_DEPTH = 8;
  localparam int ROB_W     = 3;   // tag width, ROB_DEPTH is a power of two
  localparam int RS_DEPTH  = 4;
  localparam int RS_W      = 2;   // slot index and age width

  typedef logic [XLEN-1:0]  word_t;
  typedef logic [REG_W-1:0] reg_id_t;
  typedef logic [ROB_W-1:0] rob_id_t;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLT = 3'd5   // signed less-than, result 0 or 1
  } alu_op_e;

  // decoded instruction from the front end
  typedef struct packed {
    alu_op_e op;
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    logic    use_imm;  // second operand from imm instead of rs2
    word_t   imm;
  } instr_t;

  // either a value (ready) or the ROB tag that will produce it
  typedef struct packed {
    logic    ready;
    rob_id_t tag;
    word_t   val;
  } operand_t;

  typedef struct packed {
    alu_op_e  op;
    rob_id_t  dest;
    operand_t src1;
    operand_t src2;
  } issue_rec_t;

  typedef struct packed {
    logic    valid;
    rob_id_t tag;
    word_t   val;
  } cdb_t;

  typedef struct packed {
    logic    valid;
    reg_id_t rd;
    rob_id_t tag;
    word_t   val;
  } commit_t;

endpackage

/* hdl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  logic                clear_in,
  input  logic                instr_valid,
  input  ooo_pkg::instr_t     instr,
  input  logic                rob_full,
  input  logic                rs_full,
  input  ooo_pkg::rob_id_t    alloc_tag,
  input  ooo_pkg::word_t      ask1_val,
  input  ooo_pkg::word_t      ask2_val,
  input  logic                ask1_dep,
  input  logic                ask2_dep,
  input  ooo_pkg::rob_id_t    ask1_tag,
  input  ooo_pkg::rob_id_t    ask2_tag,
  input  logic                look1_ready,
  input  logic                look2_ready,
  input  ooo_pkg::word_t      look1_val,
  input  ooo_pkg::word_t      look2_val,
  input  ooo_pkg::cdb_t       cdb,
  output logic                instr_stall,
  output logic                issue_fire,
  output ooo_pkg::reg_id_t    ask1_id,
  output ooo_pkg::reg_id_t    ask2_id,
  output ooo_pkg::reg_id_t    new_reg_id,
  output ooo_pkg::rob_id_t    new_rob_id,
  output ooo_pkg::rob_id_t    look1_tag,
  output ooo_pkg::rob_id_t    look2_tag,
  output ooo_pkg::issue_rec_t rec,
  output logic                rec_valid
);
  import ooo_pkg::*;

  operand_t src1;
  operand_t src2;

  // tagged source: take a finished ROB value, else catch it on the CDB this cycle
  function automatic operand_t resolve(input logic dep, input rob_id_t tag, input word_t val,
                                       input logic lk_ready, input word_t lk_val,
                                       input cdb_t bus);
    operand_t o;
    o.ready = 1'b1;
    o.tag   = tag;
    o.val   = val;
    if (dep) begin
      if (lk_ready) begin
        o.val = lk_val;
      end else if (bus.valid && bus.tag == tag) begin
        o.val = bus.val;
      end else begin
        o.ready = 1'b0;
      end
    end
    return o;
  endfunction

  assign instr_stall = rob_full | rs_full;
  assign issue_fire  = instr_valid & ~instr_stall & rdy_in & ~clear_in;

  assign ask1_id   = instr.rs1;
  assign ask2_id   = instr.rs2;
  assign look1_tag = ask1_tag;
  assign look2_tag = ask2_tag;

  always_comb begin
    src1 = resolve(ask1_dep, ask1_tag, ask1_val, look1_ready, look1_val, cdb);
    src2 = resolve(ask2_dep, ask2_tag, ask2_val, look2_ready, look2_val, cdb);
    if (instr.use_imm) begin
      src2.ready = 1'b1;
      src2.tag   = '0;
      src2.val   = instr.imm;
    end
  end

  // rename reaches the register file one cycle later, together with rec_valid
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      rec_valid  <= 1'b0;
      new_reg_id <= '0;
      new_rob_id <= '0;
    end else if (rdy_in) begin
      if (clear_in) begin
        rec_valid  <= 1'b0;
        new_reg_id <= '0;
      end else begin
        rec_valid  <= issue_fire;
        new_reg_id <= issue_fire ? instr.rd : '0;  // 0 means no rename
        new_rob_id <= alloc_tag;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && issue_fire) begin
      rec <= '{op: instr.op, dest: alloc_tag, src1: src1, src2: src2};
    end
  end

endmodule

/* hdl/reg_status_file.sv */
`timescale 1ns/1ps

module reg_status_file (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             rdy_in,
  input  logic             clear_in,
  input  ooo_pkg::reg_id_t ask1_id,
  input  ooo_pkg::reg_id_t ask2_id,
  input  ooo_pkg::reg_id_t new_reg_id,
  input  ooo_pkg::rob_id_t new_rob_id,
  input  ooo_pkg::commit_t commit,
  output ooo_pkg::word_t   ask1_val,
  output ooo_pkg::word_t   ask2_val,
  output logic             ask1_dep,
  output logic             ask2_dep,
  output ooo_pkg::rob_id_t ask1_tag,
  output ooo_pkg::rob_id_t ask2_tag
);
  import ooo_pkg::*;

  word_t               regs [NUM_REGS];
  rob_id_t             tags [NUM_REGS];
  logic [NUM_REGS-1:0] busy;

  operand_t res1;
  operand_t res2;

  // lookup order: x0, pending rename, value being committed, busy tag, register
  function automatic operand_t lookup(input reg_id_t id);
    operand_t o;
    o.ready = 1'b1;
    o.tag   = tags[id];
    o.val   = regs[id];
    if (id == '0) begin
      o.val = '0;
    end else if (id == new_reg_id) begin
      o.ready = 1'b0;
      o.tag   = new_rob_id;  // renamed by the instruction issued last cycle
    end else if (busy[id]) begin
      if (commit.valid && commit.rd == id && commit.tag == tags[id]) begin
        o.val = commit.val;  // final value lands this cycle
      end else begin
        o.ready = 1'b0;
      end
    end
    return o;
  endfunction

  always_comb begin
    res1 = lookup(ask1_id);
    res2 = lookup(ask2_id);
  end

  assign ask1_val = res1.val;
  assign ask1_dep = ~res1.ready;
  assign ask1_tag = res1.tag;
  assign ask2_val = res2.val;
  assign ask2_dep = ~res2.ready;
  assign ask2_tag = res2.tag;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
        tags[i] <= '0;
      end
    end else if (rdy_in) begin
      if (clear_in) begin
        // flush drops every rename, committed values stay
        busy <= '0;
        for (int i = 0; i < NUM_REGS; i++) begin
          tags[i] <= '0;
        end
      end else begin
        if (commit.valid && commit.rd != '0) begin
          regs[commit.rd] <= commit.val;
          // a younger rename still owns the register unless the tags match
          if (commit.rd != new_reg_id && tags[commit.rd] == commit.tag) begin
            busy[commit.rd] <= 1'b0;
          end
        end
        if (new_reg_id != '0) begin
          busy[new_reg_id] <= 1'b1;
          tags[new_reg_id] <= new_rob_id;
        end
      end
    end
  end

endmodule

/* hdl/rob_queue.sv */
`timescale 1ns/1ps

module rob_queue (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             rdy_in,
  input  logic             clear_in,
  input  logic             issue_fire,
  input  ooo_pkg::reg_id_t new_reg_id,
  input  ooo_pkg::cdb_t    cdb,
  input  ooo_pkg::rob_id_t look1_tag,
  input  ooo_pkg::rob_id_t look2_tag,
  output ooo_pkg::rob_id_t alloc_tag,
  output logic             rob_full,
  output logic             look1_ready,
  output logic             look2_ready,
  output ooo_pkg::word_t   look1_val,
  output ooo_pkg::word_t   look2_val,
  output ooo_pkg::commit_t commit
);
  import ooo_pkg::*;

  logic [ROB_DEPTH-1:0] done;  // result captured from the CDB
  reg_id_t              ent_rd  [ROB_DEPTH];
  word_t                ent_val [ROB_DEPTH];

  rob_id_t        head;
  rob_id_t        tail;
  logic [ROB_W:0] count;
  logic           pop;

  // rd comes with the registered rename, one cycle after allocation
  logic    fill_pend;
  rob_id_t fill_tag;

  commit_t commit_q;

  assign alloc_tag = tail;
  assign rob_full  = (count == ROB_DEPTH);
  assign pop       = (count != '0) && done[head];

  assign look1_ready = done[look1_tag];
  assign look1_val   = ent_val[look1_tag];
  assign look2_ready = done[look2_tag];
  assign look2_val   = ent_val[look2_tag];

  always_comb begin
    commit       = commit_q;
    commit.valid = commit_q.valid & rdy_in & ~clear_in;  // no pulse while paused or flushed
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      done      <= '0;
      fill_pend <= 1'b0;
      commit_q  <= '0;
    end else if (rdy_in) begin
      if (clear_in) begin
        head      <= '0;
        tail      <= '0;
        count     <= '0;
        done      <= '0;
        fill_pend <= 1'b0;
        commit_q  <= '0;
      end else begin
        fill_pend <= issue_fire;
        if (cdb.valid) begin
          done[cdb.tag] <= 1'b1;
        end
        if (pop) begin
          commit_q     <= '{valid: 1'b1, rd: ent_rd[head], tag: head, val: ent_val[head]};
          done[head]   <= 1'b0;
          head         <= head + 1'b1;  // wraps at ROB_DEPTH
        end else begin
          commit_q.valid <= 1'b0;
        end
        if (issue_fire) begin
          done[tail] <= 1'b0;
          tail       <= tail + 1'b1;
        end
        count <= count + (ROB_W+1)'(issue_fire) - (ROB_W+1)'(pop);
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && !clear_in) begin
      if (issue_fire) begin
        fill_tag <= tail;
      end
      if (fill_pend) begin
        ent_rd[fill_tag] <= new_reg_id;
      end
      if (cdb.valid) begin
        ent_val[cdb.tag] <= cdb.val;
      end
    end
  end

endmodule

/* hdl/res_station.sv */
`timescale 1ns/1ps

module res_station (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,
  input  logic                clear_in,
  input  ooo_pkg::issue_rec_t rec,
  input  logic                rec_valid,
  output logic                rs_full,
  output ooo_pkg::cdb_t       cdb
);
  import ooo_pkg::*;

  logic [RS_DEPTH-1:0] busy;
  issue_rec_t          ent [RS_DEPTH];
  logic [RS_W-1:0]     age [RS_DEPTH];  // number of younger live entries

  logic [RS_DEPTH-1:0] ready;
  logic                sel_valid;
  logic [RS_W-1:0]     sel_idx;
  logic [RS_W-1:0]     sel_age;
  logic [RS_W-1:0]     free_idx;
  logic [RS_W:0]       used;

  cdb_t alu_q;

  function automatic operand_t snoop(input operand_t o, input cdb_t bus);
    operand_t r;
    r = o;
    if (!o.ready && bus.valid && bus.tag == o.tag) begin
      r.ready = 1'b1;
      r.val   = bus.val;
    end
    return r;
  endfunction

  function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return word_t'($signed(a) < $signed(b));
      default: return '0;
    endcase
  endfunction

  // oldest ready entry has the largest age
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = '0;
    sel_age   = '0;
    free_idx  = '0;
    used      = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      ready[i] = busy[i] && ent[i].src1.ready && ent[i].src2.ready;
      if (ready[i] && (!sel_valid || age[i] > sel_age)) begin
        sel_valid = 1'b1;
        sel_idx   = RS_W'(i);
        sel_age   = age[i];
      end
      if (!busy[i]) begin
        free_idx = RS_W'(i);  // lowest free slot
      end
      used = used + (RS_W+1)'(busy[i]);
    end
  end

  // the record in flight already owns a slot
  assign rs_full = (used + rec_valid) >= RS_DEPTH;

  always_comb begin
    cdb       = alu_q;
    cdb.valid = alu_q.valid & rdy_in & ~clear_in;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy  <= '0;
      alu_q <= '0;
      for (int i = 0; i < RS_DEPTH; i++) begin
        age[i] <= '0;
      end
    end else if (rdy_in) begin
      if (clear_in) begin
        busy  <= '0;
        alu_q <= '0;  // in-flight result is dropped
      end else begin
        alu_q.valid <= sel_valid;
        alu_q.tag   <= ent[sel_idx].dest;
        alu_q.val   <= alu(ent[sel_idx].op, ent[sel_idx].src1.val, ent[sel_idx].src2.val);
        for (int i = 0; i < RS_DEPTH; i++) begin
          if (busy[i]) begin
            age[i] <= age[i] + RS_W'(rec_valid) - RS_W'(sel_valid && age[i] > sel_age);
          end
        end
        if (sel_valid) begin
          busy[sel_idx] <= 1'b0;
        end
        if (rec_valid) begin
          busy[free_idx] <= 1'b1;
          age[free_idx]  <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && !clear_in) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        ent[i].src1 <= snoop(ent[i].src1, cdb);
        ent[i].src2 <= snoop(ent[i].src2, cdb);
      end
      if (rec_valid) begin
        ent[free_idx] <= '{op: rec.op, dest: rec.dest,
                           src1: snoop(rec.src1, cdb), src2: snoop(rec.src2, cdb)};
      end
    end
  end

endmodule

/* hdl/ooo_core_top.sv */
`timescale 1ns/1ps

module ooo_core_top (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             rdy_in,
  input  logic             clear_in,
  input  logic             instr_valid,
  input  ooo_pkg::instr_t  instr,
  output logic             instr_stall,
  output ooo_pkg::commit_t commit
);
  import ooo_pkg::*;

  logic       issue_fire;
  logic       rob_full;
  logic       rs_full;
  rob_id_t    alloc_tag;
  reg_id_t    ask1_id;
  reg_id_t    ask2_id;
  word_t      ask1_val;
  word_t      ask2_val;
  logic       ask1_dep;
  logic       ask2_dep;
  rob_id_t    ask1_tag;
  rob_id_t    ask2_tag;
  reg_id_t    new_reg_id;
  rob_id_t    new_rob_id;
  rob_id_t    look1_tag;
  rob_id_t    look2_tag;
  logic       look1_ready;
  logic       look2_ready;
  word_t      look1_val;
  word_t      look2_val;
  issue_rec_t rec;
  logic       rec_valid;
  cdb_t       cdb;

  issue_stage i_issue_stage (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .clear_in    (clear_in),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rob_full    (rob_full),
    .rs_full     (rs_full),
    .alloc_tag   (alloc_tag),
    .ask1_val    (ask1_val),
    .ask2_val    (ask2_val),
    .ask1_dep    (ask1_dep),
    .ask2_dep    (ask2_dep),
    .ask1_tag    (ask1_tag),
    .ask2_tag    (ask2_tag),
    .look1_ready (look1_ready),
    .look2_ready (look2_ready),
    .look1_val   (look1_val),
    .look2_val   (look2_val),
    .cdb         (cdb),
    .instr_stall (instr_stall),
    .issue_fire  (issue_fire),
    .ask1_id     (ask1_id),
    .ask2_id     (ask2_id),
    .new_reg_id  (new_reg_id),
    .new_rob_id  (new_rob_id),
    .look1_tag   (look1_tag),
    .look2_tag   (look2_tag),
    .rec         (rec),
    .rec_valid   (rec_valid)
  );

  reg_status_file i_reg_status_file (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .clear_in   (clear_in),
    .ask1_id    (ask1_id),
    .ask2_id    (ask2_id),
    .new_reg_id (new_reg_id),
    .new_rob_id (new_rob_id),
    .commit     (commit),
    .ask1_val   (ask1_val),
    .ask2_val   (ask2_val),
    .ask1_dep   (ask1_dep),
    .ask2_dep   (ask2_dep),
    .ask1_tag   (ask1_tag),
    .ask2_tag   (ask2_tag)
  );

  rob_queue i_rob_queue (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .clear_in    (clear_in),
    .issue_fire  (issue_fire),
    .new_reg_id  (new_reg_id),
    .cdb         (cdb),
    .look1_tag   (look1_tag),
    .look2_tag   (look2_tag),
    .alloc_tag   (alloc_tag),
    .rob_full    (rob_full),
    .look1_ready (look1_ready),
    .look2_ready (look2_ready),
    .look1_val   (look1_val),
    .look2_val   (look2_val),
    .commit      (commit)
  );

  res_station i_res_station (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .clear_in  (clear_in),
    .rec       (rec),
    .rec_valid (rec_valid),
    .rs_full   (rs_full),
    .cdb       (cdb)
  );

endmodule

/* verif/ooo_core_props.sv */
`timescale 1ns/1ps

module ooo_core_props (
  input logic                    clk_in,
  input logic                    rst_in,
  input logic                    rdy_in,
  input logic                    clear_in,
  input logic                    issue_fire,
  input logic [ooo_pkg::ROB_W:0] count,
  input ooo_pkg::commit_t        commit
);
  import ooo_pkg::*;

  int                   fail_cnt = 0;
  logic [ROB_DEPTH-1:0] retired;  // tags committed since the last allocation

  always_ff @(posedge clk_in) begin
    if (rst_in || clear_in || issue_fire) begin
      retired <= '0;
    end
    if (commit.valid) begin
      retired[commit.tag] <= 1'b1;
    end
  end

  assert property (@(posedge clk_in) disable iff (rst_in) count <= ROB_DEPTH)
    else begin
      fail_cnt++;
      $error("rob count %0d above depth", count);
    end

  // reset and flush leave no pulse in their own cycle or the next one
  assert property (@(posedge clk_in)
                   (rst_in || (rdy_in && clear_in)) |-> !commit.valid ##1 !commit.valid)
    else begin
      fail_cnt++;
      $error("commit pulse during or right after reset or flush");
    end

  // a tag comes back only after the slot was allocated again
  assert property (@(posedge clk_in) disable iff (rst_in) commit.valid |-> !retired[commit.tag])
    else begin
      fail_cnt++;
      $error("tag %0d committed twice", commit.tag);
    end

endmodule

/* verif/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int MAX_ROWS     = 40;
  localparam int ACCEPT_LIMIT = 200;  // cycles one instruction may wait on instr_stall
  localparam int DRAIN_LIMIT  = 400;
  localparam int PAUSE_CYCLES = 6;

  logic    clk_in;
  logic    rst_in;
  logic    rdy_in;
  logic    clear_in;
  logic    instr_valid;
  instr_t  instr;
  logic    instr_stall;
  commit_t commit;

  // stimulus table with expected columns filled by predict()
  string   names    [MAX_ROWS];
  instr_t  rows     [MAX_ROWS];
  int      gaps     [MAX_ROWS];
  bit      pause_at [MAX_ROWS];
  bit      flush_at [MAX_ROWS];
  reg_id_t exp_rd   [MAX_ROWS];
  word_t   exp_val  [MAX_ROWS];
  rob_id_t exp_tag  [MAX_ROWS];  // ROB slot in allocation order
  int      n_rows;

  word_t   arch [NUM_REGS];  // architectural state after the last observed commit
  int      pend_q [$];       // accepted rows in program order
  commit_t got_q [$];

  logic [31:0] rng       = 32'd15973;
  int          err_cnt   = 0;
  int          n_pass    = 0;
  int          n_fail    = 0;
  int          n_flushed = 0;
  int          n_alloc   = 0;  // allocations since reset or the last flush
  bit          saw_stall = 1'b0;
  bit          hung      = 1'b0;

  ooo_core_top i_ooo_core_top (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .clear_in    (clear_in),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_stall (instr_stall),
    .commit      (commit)
  );

  bind rob_queue ooo_core_props i_ooo_core_props (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .clear_in   (clear_in),
    .issue_fire (issue_fire),
    .count      (count),
    .commit     (commit)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // architectural result of one operation
  function automatic word_t model_op(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  task automatic add_row(input string name, input alu_op_e op, input int rd, input int rs1,
                         input int rs2, input bit use_imm, input word_t imm,
                         input bit rand_gap, input bit pause, input bit flush);
    names[n_rows]    = name;
    rows[n_rows]     = '{op: op, rd: reg_id_t'(rd), rs1: reg_id_t'(rs1),
                         rs2: reg_id_t'(rs2), use_imm: use_imm, imm: imm};
    gaps[n_rows]     = rand_gap ? int'(next_rand() % 4) : 0;
    pause_at[n_rows] = pause;
    flush_at[n_rows] = flush;
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    add_row("li_x1", OP_ADD, 1, 0, 0, 1'b1, next_rand(), 1'b1, 1'b0, 1'b0);
    add_row("li_x2", OP_ADD, 2, 0, 0, 1'b1, next_rand(), 1'b0, 1'b0, 1'b0);
    add_row("add_dep", OP_ADD, 3, 1, 2, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("sub_dep", OP_SUB, 4, 3, 1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("xor_dep", OP_XOR, 5, 4, 3, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("slt_neg", OP_SLT, 6, 5, 0, 1'b1, 32'hffff_fffb, 1'b1, 1'b0, 1'b0);
    add_row("slt_reg", OP_SLT, 7, 2, 1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("and_imm", OP_AND, 8, 3, 0, 1'b1, next_rand(), 1'b1, 1'b0, 1'b0);
    add_row("or_dep", OP_OR, 9, 8, 4, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    // x0 takes the write but keeps reading zero
    add_row("wr_x0", OP_ADD, 0, 1, 2, 1'b0, '0, 1'b1, 1'b0, 1'b0);
    add_row("rd_x0", OP_ADD, 10, 0, 9, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("x0_imm", OP_OR, 11, 0, 0, 1'b1, next_rand(), 1'b1, 1'b0, 1'b0);
    // x12 renamed twice while both are in flight
    add_row("waw_old", OP_ADD, 12, 3, 0, 1'b1, 32'd7, 1'b0, 1'b0, 1'b0);
    add_row("waw_read", OP_SUB, 14, 12, 2, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("waw_new", OP_XOR, 12, 5, 0, 1'b1, next_rand(), 1'b0, 1'b0, 1'b0);
    add_row("waw_use", OP_ADD, 15, 12, 0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    for (int k = 0; k < 12; k++) begin
      if (k % 2 == 0) begin
        add_row($sformatf("burst_%0d", k), OP_ADD, 13, 13, 0, 1'b1, next_rand(),
                1'b0, 1'b0, 1'b0);
      end else begin
        add_row($sformatf("burst_%0d", k), OP_XOR, 13, 13, 1, 1'b0, '0, 1'b0, 1'b0, 1'b0);
      end
    end
    add_row("pause_mid", OP_SLT, 16, 13, 1, 1'b0, '0, 1'b0, 1'b1, 1'b0);
    add_row("after_pause", OP_ADD, 17, 16, 13, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    add_row("pre_flush", OP_ADD, 18, 17, 3, 1'b0, '0, 1'b1, 1'b0, 1'b0);
    add_row("flush_mid", OP_SUB, 18, 18, 0, 1'b1, next_rand(), 1'b0, 1'b0, 1'b1);
    add_row("post_flush", OP_ADD, 19, 18, 17, 1'b0, '0, 1'b1, 1'b0, 1'b0);
    add_row("post_chain", OP_XOR, 20, 19, 12, 1'b0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  // program-order results for rows from..end starting at the committed state
  task automatic predict(input int from);
    word_t m [NUM_REGS];
    word_t a;
    word_t b;
    m = arch;
    for (int i = from; i < n_rows; i++) begin
      a          = m[rows[i].rs1];
      b          = rows[i].use_imm ? rows[i].imm : m[rows[i].rs2];
      exp_rd[i]  = rows[i].rd;
      exp_val[i] = model_op(rows[i].op, a, b);
      if (rows[i].rd != '0) begin
        m[rows[i].rd] = exp_val[i];
      end
    end
  endtask

  task automatic check_commit(input int r, input commit_t c);
    if (c.rd != exp_rd[r] || c.tag != exp_tag[r] || c.val != exp_val[r]) begin
      $display("ERR %s expected x%0d tag %0d %h actual x%0d tag %0d %h", names[r],
               exp_rd[r], exp_tag[r], exp_val[r], c.rd, c.tag, c.val);
      n_fail++;
      err_cnt++;
    end else begin
      $display("ok   %s x%0d = %h", names[r], c.rd, c.val);
      n_pass++;
    end
    if (exp_rd[r] != '0) begin
      arch[exp_rd[r]] = exp_val[r];
    end
  endtask

  task automatic pause_core();
    rdy_in = 1'b0;
    repeat (PAUSE_CYCLES) begin
      @(posedge clk_in);
      if (commit.valid) begin
        $display("commit pulse seen while rdy_in was low");
        err_cnt++;
      end
    end
    @(negedge clk_in);
    rdy_in = 1'b1;
  endtask

  task automatic flush_core(input int r);
    int gone;
    @(negedge clk_in);  // one idle cycle then a one-cycle clear
    clear_in = 1'b1;
    @(negedge clk_in);
    clear_in = 1'b0;
    n_alloc  = 0;
    while (pend_q.size() != 0) begin
      gone = pend_q.pop_front();
      $display("flushed %s", names[gone]);
      n_flushed++;
    end
    predict(r + 1);
  endtask

  // commit monitor sampled at the edge where the core retires
  always @(posedge clk_in) begin
    commit_t c;
    int      r;
    if (!rst_in && commit.valid) begin
      got_q.push_back(commit);
    end
    while (got_q.size() != 0) begin
      c = got_q.pop_front();
      if (pend_q.size() == 0) begin
        $display("unexpected commit of tag %0d with nothing outstanding", c.tag);
        err_cnt++;
      end else begin
        r = pend_q.pop_front();
        check_commit(r, c);
      end
    end
  end

  initial begin
    int waited;
    bit accepted;
    rst_in      = 1'b1;
    rdy_in      = 1'b0;
    clear_in    = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      arch[i] = '0;
    end
    build_table();
    predict(0);
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    rdy_in = 1'b1;

    for (int r = 0; r < n_rows && !hung; r++) begin
      repeat (gaps[r]) @(negedge clk_in);
      instr_valid = 1'b1;
      instr       = rows[r];
      accepted    = 1'b0;
      waited      = 0;
      while (!accepted && waited < ACCEPT_LIMIT) begin
        @(posedge clk_in);
        saw_stall = saw_stall | instr_stall;
        accepted  = !instr_stall;  // rdy_in is high and clear_in low here
        waited++;
      end
      @(negedge clk_in);
      instr_valid = 1'b0;
      if (!accepted) begin
        $display("timeout: %s was never accepted", names[r]);
        hung = 1'b1;
      end else begin
        exp_tag[r] = rob_id_t'(n_alloc);
        n_alloc++;
        pend_q.push_back(r);
        if (pause_at[r]) begin
          pause_core();
        end
        if (flush_at[r]) begin
          flush_core(r);
        end
      end
    end

    waited = 0;
    while (pend_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk_in);
      waited++;
    end
    if (pend_q.size() != 0) begin
      $display("timeout: %0d accepted instructions never committed", pend_q.size());
      hung = 1'b1;
    end
    repeat (10) @(posedge clk_in);  // stray commits show up as unexpected
    if (!saw_stall) begin
      $display("instr_stall never rose during the burst");
      err_cnt++;
    end
    if (i_ooo_core_top.i_rob_queue.i_ooo_core_props.fail_cnt != 0) begin
      $display("assertions failed %0d times",
               i_ooo_core_top.i_rob_queue.i_ooo_core_props.fail_cnt);
      err_cnt++;
    end
    $display("tests: %0d passed, %0d failed, %0d flushed, %0d errors",
             n_pass, n_fail, n_flushed, err_cnt);
    if (err_cnt == 0 && !hung) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/ooo_pkg.sv
hdl/issue_stage.sv
hdl/reg_status_file.sv
hdl/rob_queue.sv
hdl/res_station.sv
hdl/ooo_core_top.sv
verif/ooo_core_props.sv
verif/ooo_core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  # synthesizable core, package first
  - files:
      - hdl/ooo_pkg.sv
      - hdl/issue_stage.sv
      - hdl/reg_status_file.sv
      - hdl/rob_queue.sv
      - hdl/res_station.sv
      - hdl/ooo_core_top.sv
  # simulation only
  - target: test
    files:
      - verif/ooo_core_props.sv
      - verif/ooo_core_tb.sv
